//--- hw/memPkg.sv
////////////////////
// Shared memory sizes and types
////////////////////

package memPkg;

   // Geometry
   localparam int addrW  = 10;              // 1024 words
   localparam int colW   = 8;               // One byte lane
   localparam int numCol = 4;
   localparam int dataW  = numCol * colW;   // 32-bit word
   localparam int laneW  = 2;               // Selects one of numCol lanes

   // Payload types
   typedef logic [dataW-1:0] wordT;
   typedef logic [colW-1:0]  byteT;

   // Per-lane write enable, bit i drives lane i
   typedef logic [numCol-1:0] beT;

   // Addressing
   typedef logic [addrW-1:0]       wordAddrT;
   typedef logic [addrW+laneW-1:0] byteAddrT;  // Word address above the lane bits
   typedef logic [laneW-1:0]       laneT;

endpackage

//--- hw/ramColumn.sv
////////////////////
// Byte column RAM
////////////////////

`timescale 1ns/1ps

module ramColumn (
   input  logic             clkA,
   // Port A
   input  logic             enA,
   input  logic             weA,
   input  memPkg::wordAddrT addrA,
   input  memPkg::byteT     dinA,
   output memPkg::byteT     doutA,
   // Port B
   input  logic             enB,
   input  logic             weB,
   input  memPkg::wordAddrT addrB,
   input  memPkg::byteT     dinB,
   output memPkg::byteT     doutB
);
   import memPkg::*;

   byteT mem [0:(2**addrW)-1];  // No initial contents

   // Port A, read-first
   always @(posedge clkA) begin
      if (enA) begin
         if (weA) begin
            mem[addrA] <= dinA;
         end
         doutA <= mem[addrA];  // Old byte on a write
      end
   end

   // Port B, same rules on the same clock
   always @(posedge clkA) begin
      if (enB) begin
         if (weB) begin
            mem[addrB] <= dinB;
         end
         doutB <= mem[addrB];
      end
   end

   // Both outputs hold while their enable is low

endmodule

//--- hw/ramByteEnable.sv
////////////////////
// Byte-enable word RAM
////////////////////

`timescale 1ns/1ps

module ramByteEnable (
   input  logic             clkA,
   // Port A
   input  logic             enA,
   input  memPkg::beT       weA,
   input  memPkg::wordAddrT addrA,
   input  memPkg::wordT     dinA,
   output memPkg::wordT     doutA,
   // Port B
   input  logic             enB,
   input  memPkg::beT       weB,
   input  memPkg::wordAddrT addrB,
   input  memPkg::wordT     dinB,
   output memPkg::wordT     doutB
);
   import memPkg::*;

   // One column per byte lane
   // Lane i takes bit i of each enable and bits [i*colW +: colW] of each bus
   for (genvar i = 0; i < numCol; i++) begin : genCol
      ramColumn col (
         .clkA  (clkA),
         .enA   (enA),
         .weA   (weA[i]),
         .addrA (addrA),
         .dinA  (dinA[i*colW +: colW]),
         .doutA (doutA[i*colW +: colW]),
         .enB   (enB),
         .weB   (weB[i]),
         .addrB (addrB),
         .dinB  (dinB[i*colW +: colW]),
         .doutB (doutB[i*colW +: colW])
      );
   end

   // Both ports share the address across all lanes,
   // so a word read returns every column at once

endmodule

//--- hw/bytePortAdapter.sv
////////////////////
// Byte port to word access adapter
////////////////////

`timescale 1ns/1ps

module bytePortAdapter (
   input  logic             clkA,
   input  logic             rstN,
   // Byte-wide request side
   input  logic             enB,
   input  logic             wrB,
   input  memPkg::byteAddrT byteAddrB,
   input  memPkg::byteT     dinB,
   output memPkg::byteT     doutB,
   // Word-wide RAM side
   output logic             ramEnB,
   output memPkg::beT       ramWeB,
   output memPkg::wordAddrT ramAddrB,
   output memPkg::wordT     ramDinB,
   input  memPkg::wordT     ramDout
);
   import memPkg::*;

   laneT lane;   // Lane of the current request
   laneT laneQ;  // Lane of the request the RAM is answering

   // Address split
   assign ramAddrB = byteAddrB[addrW+laneW-1:laneW];
   assign lane     = byteAddrB[laneW-1:0];

   assign ramEnB  = enB;
   assign ramDinB = {numCol{dinB}};  // Only the enabled lane is written

   // One-hot lane decode for writes
   always_comb begin
      for (int i = 0; i < numCol; i++) begin
         ramWeB[i] = wrB && (lane == laneT'(i));
      end
   end

   // Track lane alongside the RAM's one cycle read latency
   always_ff @(posedge clkA or negedge rstN) begin
      if (!rstN) begin
         laneQ <= '0;
      end else if (enB) begin
         laneQ <= lane;
      end
   end

   // Laneq holds while enB is low, as does the RAM word,
   // so the selected byte holds too
   assign doutB = ramDout[laneQ*colW +: colW];

endmodule

//--- hw/writeCollisionMonitor.sv
////////////////////
// Write collision monitor
////////////////////

`timescale 1ns/1ps

module writeCollisionMonitor (
   input  logic             clkA,
   input  logic             rstN,
   // Port A as seen by the RAM
   input  logic             enA,
   input  memPkg::beT       weA,
   input  memPkg::wordAddrT addrA,
   // Port B as seen by the RAM
   input  logic             enB,
   input  memPkg::beT       weB,
   input  memPkg::wordAddrT addrB,
   output logic             collision
);
   import memPkg::*;

   beT   laneOverlap;
   logic sameWord;
   logic hit;

   assign laneOverlap = weA & weB;      // Lanes both ports write
   assign sameWord    = (addrA == addrB);

   // Both enabled, same word, at least one shared lane
   assign hit = enA && enB && sameWord && (|laneOverlap);

   // Registered so the pulse lines up with the RAM outputs
   always_ff @(posedge clkA or negedge rstN) begin
      if (!rstN) begin
         collision <= 1'b0;
      end else begin
         collision <= hit;  // One cycle per colliding request
      end
   end

   // Different lanes of the same word are not a collision

endmodule

//--- hw/sharedMemTop.sv
////////////////////
// Shared dual-port memory
////////////////////

`timescale 1ns/1ps

module sharedMemTop (
   input  logic             clkA,
   input  logic             rstN,
   // Port A, word access
   input  logic             enA,
   input  memPkg::beT       weA,
   input  memPkg::wordAddrT addrA,
   input  memPkg::wordT     dinA,
   output memPkg::wordT     doutA,
   // Port B, byte access
   input  logic             enB,
   input  logic             wrB,
   input  memPkg::byteAddrT byteAddrB,
   input  memPkg::byteT     dinB,
   output memPkg::byteT     doutB,
   // Status
   output logic             collision
);
   import memPkg::*;

   // RAM port B, driven by the adapter
   logic     ramEnB;
   beT       ramWeB;
   wordAddrT ramAddrB;
   wordT     ramDinB;
   wordT     ramDoutB;

   bytePortAdapter adapter (
      .clkA      (clkA),
      .rstN      (rstN),
      .enB       (enB),
      .wrB       (wrB),
      .byteAddrB (byteAddrB),
      .dinB      (dinB),
      .doutB     (doutB),
      .ramEnB    (ramEnB),
      .ramWeB    (ramWeB),
      .ramAddrB  (ramAddrB),
      .ramDinB   (ramDinB),
      .ramDout   (ramDoutB)
   );

   // Port A goes straight into the RAM
   ramByteEnable ram (
      .clkA  (clkA),
      .enA   (enA),
      .weA   (weA),
      .addrA (addrA),
      .dinA  (dinA),
      .doutA (doutA),
      .enB   (ramEnB),
      .weB   (ramWeB),
      .addrB (ramAddrB),
      .dinB  (ramDinB),
      .doutB (ramDoutB)
   );

   // Watches the RAM-side signals of both ports
   writeCollisionMonitor monitor (
      .clkA      (clkA),
      .rstN      (rstN),
      .enA       (enA),
      .weA       (weA),
      .addrA     (addrA),
      .enB       (ramEnB),
      .weB       (ramWeB),
      .addrB     (ramAddrB),
      .collision (collision)
   );

endmodule

//--- verif/sharedMemAsserts.sv
////////////////////
// Shared memory timing checks
////////////////////

`timescale 1ns/1ps

module sharedMemAsserts (
   input logic             clkA,
   input logic             rstN,
   input logic             enA,
   input memPkg::beT       weA,
   input memPkg::wordAddrT addrA,
   input memPkg::wordT     doutA,
   input logic             enB,
   input logic             wrB,
   input memPkg::byteAddrT byteAddrB,
   input memPkg::byteT     doutB,
   input logic             collision
);
   import memPkg::*;

   logic written [0:(2**(addrW+laneW))-1];  // One flag per byte address

   initial begin
      for (int i = 0; i < 2**(addrW+laneW); i++) begin
         written[i] = 1'b0;
      end
   end

   // Byte addresses that hold known data
   always @(posedge clkA) begin
      for (int i = 0; i < numCol; i++) begin
         if (enA && weA[i]) begin
            written[{addrA, laneT'(i)}] <= 1'b1;
         end
      end
      if (enB && wrB) begin
         written[byteAddrB] <= 1'b1;
      end
   end

   collisionNeedsWrites: assert property (@(posedge clkA) disable iff (!rstN)
      collision |-> $past(enA && enB && (|weA) && wrB))
      else $error("collision without writes on both ports in the previous cycle");

   doutAHolds: assert property (@(posedge clkA) disable iff (!rstN)
      (!enA && !$isunknown(doutA)) |=> $stable(doutA))
      else $error("doutA changed after a cycle with enA low");

   doutBKnown: assert property (@(posedge clkA) disable iff (!rstN)
      (enB && written[byteAddrB]) |=> !$isunknown(doutB))
      else $error("doutB has unknown bits after reading a written byte");

endmodule

bind sharedMemTop sharedMemAsserts asserts (
   .clkA      (clkA),
   .rstN      (rstN),
   .enA       (enA),
   .weA       (weA),
   .addrA     (addrA),
   .doutA     (doutA),
   .enB       (enB),
   .wrB       (wrB),
   .byteAddrB (byteAddrB),
   .doutB     (doutB),
   .collision (collision)
);

//--- verif/sharedMemTb.sv
////////////////////
// Shared memory testbench
////////////////////

`timescale 1ns/1ps

module sharedMemTb;
   import memPkg::*;

   localparam int clkPeriod   = 8;
   localparam int resetCycles = 10;

   typedef struct packed {
      logic     enA;
      beT       weA;
      wordAddrT addrA;
      wordT     dinA;
      logic     enB;
      logic     wrB;
      byteAddrT byteAddrB;
      byteT     dinB;
      logic     chkA;     // Compare doutA next cycle
      logic     chkB;     // Compare doutB next cycle
      logic     expColl;
   } rowT;

   // DUT signals
   logic     clkA;
   logic     rstN;
   logic     enA;
   beT       weA;
   wordAddrT addrA;
   wordT     dinA;
   wordT     doutA;
   logic     enB;
   logic     wrB;
   byteAddrT byteAddrB;
   byteT     dinB;
   byteT     doutB;
   logic     collision;

   rowT    rows[$];
   wordT   model [0:(2**addrW)-1];  // Reference contents that stay unknown until written
   integer seed = 32'hc45f;
   logic   tableReady = 1'b0;

   // Expectations for the row applied on the previous cycle
   wordT expA;
   byteT expB;
   logic pendChkA = 1'b0;
   logic pendChkB = 1'b0;
   logic pendColl = 1'b0;

   sharedMemTop dut (
      .clkA      (clkA),
      .rstN      (rstN),
      .enA       (enA),
      .weA       (weA),
      .addrA     (addrA),
      .dinA      (dinA),
      .doutA     (doutA),
      .enB       (enB),
      .wrB       (wrB),
      .byteAddrB (byteAddrB),
      .dinB      (dinB),
      .doutB     (doutB),
      .collision (collision)
   );

   initial begin
      clkA = 1'b0;
      forever #(clkPeriod/2) clkA = ~clkA;
   end

   function automatic wordT nextWord();
      nextWord = $random(seed);
   endfunction

   function automatic byteT nextByte();
      nextByte = byteT'($random(seed));
   endfunction

   function automatic byteAddrT byteAddr(input wordAddrT w, input laneT l);
      byteAddr = {w, l};
   endfunction

   task automatic checkWord(input string name, input wordT exp, input wordT act);
      if (act !== exp) begin
         $display("ERR %s expected 0x%h got 0x%h", name, exp, act);
         $display("Test failures found");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic checkByte(input string name, input byteT exp, input byteT act);
      if (act !== exp) begin
         $display("ERR %s expected 0x%h got 0x%h", name, exp, act);
         $display("Test failures found");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic checkFlag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR %s expected 0x%h got 0x%h", name, exp, act);
         $display("Test failures found");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic addRow(input logic aEn, input beT aWe, input wordAddrT aAddr,
                         input wordT aDin, input logic bEn, input logic bWr,
                         input byteAddrT bAddr, input byteT bDin,
                         input logic aChk, input logic bChk, input logic coll);
      rowT r;
      r.enA       = aEn;
      r.weA       = aWe;
      r.addrA     = aAddr;
      r.dinA      = aDin;
      r.enB       = bEn;
      r.wrB       = bWr;
      r.byteAddrB = bAddr;
      r.dinB      = bDin;
      r.chkA      = aChk;
      r.chkB      = bChk;
      r.expColl   = coll;
      rows.push_back(r);
   endtask

   task automatic buildTable();
      // Full-word writes followed by reads
      addRow(1, 4'hF, 5, nextWord(), 0, 0, 0, 0, 0, 0, 0);
      addRow(1, 4'hF, 6, nextWord(), 0, 0, 0, 0, 0, 0, 0);
      addRow(1, 4'hF, 7, nextWord(), 0, 0, 0, 0, 0, 0, 0);
      addRow(1, 4'hF, 5, nextWord(), 0, 0, 0, 0, 1, 0, 0);  // Returns first word
      addRow(1, 4'h0, 5, 0, 0, 0, 0, 0, 1, 0, 0);
      addRow(1, 4'h0, 6, 0, 0, 0, 0, 0, 1, 0, 0);
      addRow(1, 4'h0, 7, 0, 0, 0, 0, 0, 1, 0, 0);
      // Partial byte enables
      addRow(1, 4'h5, 6, nextWord(), 0, 0, 0, 0, 1, 0, 0);
      addRow(1, 4'h8, 6, nextWord(), 0, 0, 0, 0, 1, 0, 0);
      addRow(1, 4'h0, 6, 0, 0, 0, 0, 0, 1, 0, 0);
      // Byte port writes seen on port A and port A data seen per lane
      addRow(0, 4'h0, 0, 0, 1, 1, byteAddr(7, 0), nextByte(), 0, 1, 0);
      addRow(0, 4'h0, 0, 0, 1, 1, byteAddr(7, 2), nextByte(), 0, 1, 0);
      addRow(1, 4'h0, 7, 0, 1, 0, byteAddr(6, 0), 0, 1, 1, 0);
      addRow(0, 4'h0, 0, 0, 1, 0, byteAddr(6, 1), 0, 1, 1, 0);
      addRow(0, 4'h0, 0, 0, 1, 0, byteAddr(6, 2), 0, 0, 1, 0);
      addRow(0, 4'h0, 0, 0, 1, 0, byteAddr(6, 3), 0, 0, 1, 0);
      // Different lanes of the same word
      addRow(1, 4'hF, 8, nextWord(), 0, 0, 0, 0, 0, 0, 0);
      addRow(1, 4'h3, 8, nextWord(), 1, 1, byteAddr(8, 3), nextByte(), 1, 1, 0);
      addRow(1, 4'h0, 8, 0, 1, 0, byteAddr(8, 3), 0, 1, 1, 0);
      addRow(0, 4'h0, 0, 0, 1, 0, byteAddr(8, 0), 0, 1, 1, 0);
      // Overlapping lane pulses collision for one cycle
      addRow(1, 4'hF, 9, nextWord(), 0, 0, 0, 0, 0, 0, 0);
      addRow(1, 4'h4, 9, nextWord(), 1, 1, byteAddr(9, 2), nextByte(), 0, 0, 1);
      addRow(0, 4'h0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
      // Back to back on both ports
      addRow(1, 4'hF, 10, nextWord(), 1, 0, byteAddr(5, 0), 0, 0, 1, 0);
      addRow(1, 4'hF, 11, nextWord(), 1, 0, byteAddr(5, 1), 0, 0, 1, 0);
      addRow(1, 4'h0, 10, 0, 1, 0, byteAddr(5, 2), 0, 1, 1, 0);
      addRow(1, 4'h0, 11, 0, 1, 1, byteAddr(10, 1), nextByte(), 1, 1, 0);
      addRow(1, 4'h0, 10, 0, 1, 0, byteAddr(10, 1), 0, 1, 1, 0);
      // Idle rows where outputs hold
      addRow(0, 4'h0, 0, 0, 0, 0, 0, 0, 1, 1, 0);
      addRow(0, 4'h0, 0, 0, 0, 0, 0, 0, 1, 1, 0);
      addRow(0, 4'h0, 0, 0, 0, 0, 0, 0, 1, 1, 0);
   endtask

   // Work out next-cycle expectations, update the model, then drive the DUT
   task automatic driveRow(input rowT r);
      wordAddrT wordB;
      laneT     laneB;
      wordB = r.byteAddrB[addrW+laneW-1:laneW];
      laneB = r.byteAddrB[laneW-1:0];
      if (r.enA) begin
         expA = model[r.addrA];  // Read-first
      end
      if (r.enB) begin
         expB = model[wordB][laneB*colW +: colW];
      end
      for (int i = 0; i < numCol; i++) begin
         if (r.enA && r.weA[i]) begin
            model[r.addrA][i*colW +: colW] = r.dinA[i*colW +: colW];
         end
      end
      if (r.enB && r.wrB) begin
         if (r.enA && r.weA[laneB] && (r.addrA == wordB)) begin
            model[wordB][laneB*colW +: colW] = 'x;  // Collided byte undefined
         end else begin
            model[wordB][laneB*colW +: colW] = r.dinB;
         end
      end
      pendChkA  = r.chkA;
      pendChkB  = r.chkB;
      pendColl  = r.expColl;
      enA       = r.enA;
      weA       = r.weA;
      addrA     = r.addrA;
      dinA      = r.dinA;
      enB       = r.enB;
      wrB       = r.wrB;
      byteAddrB = r.byteAddrB;
      dinB      = r.dinB;
   endtask

   task automatic checkResults();
      if (pendChkA) begin
         checkWord("doutA", expA, doutA);
      end
      if (pendChkB) begin
         checkByte("doutB", expB, doutB);
      end
      checkFlag("collision", pendColl, collision);  // Known from reset on
   endtask

   initial begin
      rstN      = 1'b0;
      enA       = 1'b0;
      weA       = '0;
      addrA     = '0;
      dinA      = '0;
      enB       = 1'b0;
      wrB       = 1'b0;
      byteAddrB = '0;
      dinB      = '0;
      buildTable();
      tableReady = 1'b1;
      repeat (resetCycles) @(posedge clkA);
      #1 rstN = 1'b1;
      for (int i = 0; i < rows.size(); i++) begin
         @(posedge clkA);
         #1;
         checkResults();
         driveRow(rows[i]);
      end
      @(posedge clkA);
      #1;
      checkResults();  // Last row's results
      $display("All tests passed!");
      $finish;
   end

   // Watchdog
   initial begin
      wait (tableReady);
      #((rows.size() + resetCycles + 50) * clkPeriod);
      $display("Run timed out before the stimulus table finished");
      $display("Test failures found");
      $fatal(1, "watchdog expired");
   end

endmodule

//--- all.f
hw/memPkg.sv
hw/ramColumn.sv
hw/ramByteEnable.sv
hw/bytePortAdapter.sv
hw/writeCollisionMonitor.sv
hw/sharedMemTop.sv
verif/sharedMemAsserts.sv
verif/sharedMemTb.sv
